// File: chipset_pkg.sv
`default_nettype none

package chipset_pkg;

    // Bus widths
    localparam int ADDR_W   = 20;
    localparam int DATA_W   = 8;
    localparam int STATUS_W = 3;

    // 8088 status codes
    localparam logic [STATUS_W-1:0] STATUS_INTA       = 3'd0;
    localparam logic [STATUS_W-1:0] STATUS_IO_READ    = 3'd1;
    localparam logic [STATUS_W-1:0] STATUS_IO_WRITE   = 3'd2;
    localparam logic [STATUS_W-1:0] STATUS_HALT       = 3'd3;
    localparam logic [STATUS_W-1:0] STATUS_CODE_FETCH = 3'd4;
    localparam logic [STATUS_W-1:0] STATUS_MEM_READ   = 3'd5;
    localparam logic [STATUS_W-1:0] STATUS_MEM_WRITE  = 3'd6;
    localparam logic [STATUS_W-1:0] STATUS_PASSIVE    = 3'd7;

    // On-chip RAM window
    localparam int RAM_WORDS  = 1024;
    localparam int RAM_ADDR_W = 10;
    localparam logic [ADDR_W-1:0] RAM_BASE = 20'h00000;

    // Wait states
    localparam int WAIT_W = 2;
    localparam logic [WAIT_W-1:0] IO_WAIT_STATES = 2'd1;

    // Refresh bus hold length in clocks
    localparam int REFRESH_CYCLES = 4;
    localparam int REFRESH_CNT_W  = $clog2(REFRESH_CYCLES);

endpackage

`default_nettype wire

// File: bus_controller.sv
`timescale 1ns/10ps
`default_nettype none

module bus_controller
    import chipset_pkg::*;
(
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire logic [STATUS_W-1:0] processor_status,
    input  wire logic [ADDR_W-1:0]   cpu_address,
    input  wire logic [DATA_W-1:0]   cpu_data_bus,
    input  wire logic                address_enable_n,
    output logic      [ADDR_W-1:0]   address,
    output logic      [DATA_W-1:0]   data_bus,
    output logic                     address_latch_enable,
    output logic                     io_read_n,
    output logic                     io_write_n,
    output logic                     memory_read_n,
    output logic                     memory_write_n,
    output logic                     no_command_state
);

    // One-hot command kind: io read, io write, mem read, mem write
    logic [3:0] decoded_command;
    logic [3:0] pending_command;
    logic       cycle_latch;
    logic       cycle_command;
    logic       cycle_idle;

    always_comb
    begin
        case (processor_status)
            STATUS_IO_READ:    decoded_command = 4'b0001;
            STATUS_IO_WRITE:   decoded_command = 4'b0010;
            STATUS_CODE_FETCH: decoded_command = 4'b0100;
            STATUS_MEM_READ:   decoded_command = 4'b0100;
            STATUS_MEM_WRITE:  decoded_command = 4'b1000;
            // No command for these
            STATUS_INTA:       decoded_command = 4'b0000;
            STATUS_HALT:       decoded_command = 4'b0000;
            STATUS_PASSIVE:    decoded_command = 4'b0000;
            default:           decoded_command = 4'b0000;
        endcase
    end

    assign cycle_idle = ~cycle_latch & ~cycle_command;

    assign no_command_state = io_read_n & io_write_n & memory_read_n & memory_write_n;

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            address              <= '0;
            data_bus             <= '0;
            address_latch_enable <= 1'b0;
            pending_command      <= 4'b0000;
            cycle_latch          <= 1'b0;
            cycle_command        <= 1'b0;
            io_read_n            <= 1'b1;
            io_write_n           <= 1'b1;
            memory_read_n        <= 1'b1;
            memory_write_n       <= 1'b1;
        end
        else
        begin
            address_latch_enable <= 1'b0;

            if (cycle_idle)
            begin
                // New cycle, deferred while refresh owns the bus
                if ((processor_status != STATUS_PASSIVE) && address_enable_n)
                begin
                    address_latch_enable <= 1'b1;
                    address              <= cpu_address;
                    data_bus             <= cpu_data_bus;
                    pending_command      <= decoded_command;
                    cycle_latch          <= 1'b1;
                end
            end
            else if (cycle_latch)
            begin
                // A refresh granted on the accept edge still holds off the command
                if (address_enable_n)
                begin
                    cycle_latch    <= 1'b0;
                    cycle_command  <= 1'b1;
                    io_read_n      <= ~pending_command[0];
                    io_write_n     <= ~pending_command[1];
                    memory_read_n  <= ~pending_command[2];
                    memory_write_n <= ~pending_command[3];
                end
            end
            else
            begin
                if (processor_status == STATUS_PASSIVE)
                begin
                    cycle_command  <= 1'b0;
                    io_read_n      <= 1'b1;
                    io_write_n     <= 1'b1;
                    memory_read_n  <= 1'b1;
                    memory_write_n <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: ready_generator.sv
`timescale 1ns/10ps
`default_nettype none

module ready_generator
    import chipset_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic io_read_n,
    input  wire logic io_write_n,
    input  wire logic memory_read_n,
    input  wire logic memory_write_n,
    input  wire logic io_channel_ready,
    input  wire logic memory_access_ready,
    output logic      processor_ready
);

    logic              command_active;
    logic              command_active_d;
    logic              io_command;
    logic [WAIT_W-1:0] wait_count;

    assign command_active = ~(io_read_n & io_write_n & memory_read_n & memory_write_n);
    assign io_command     = ~io_read_n | ~io_write_n;

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            command_active_d <= 1'b0;
            wait_count       <= '0;
            processor_ready  <= 1'b0;
        end
        else
        begin
            command_active_d <= command_active;

            if (~command_active)
            begin
                processor_ready <= 1'b0;
            end
            else if (~command_active_d)
            begin
                // Command just started
                wait_count      <= io_command ? IO_WAIT_STATES : '0;
                processor_ready <= 1'b0;
            end
            else if (wait_count != '0)
            begin
                wait_count <= wait_count - 1'b1;
            end
            else
            begin
                // Held until the command ends
                if (io_channel_ready & memory_access_ready)
                begin
                    processor_ready <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: refresh_dma.sv
`timescale 1ns/10ps
`default_nettype none

module refresh_dma
    import chipset_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic refresh_timer,
    input  wire logic no_command_state,
    output logic      dma0_acknowledge_n,
    output logic      address_enable_n
);

    logic                     timer_sample;
    logic                     timer_rise;
    logic                     dma0_request;
    logic                     refresh_active;
    logic                     grant;
    logic [REFRESH_CNT_W-1:0] refresh_count;

    assign timer_rise = refresh_timer & ~timer_sample;

    // Only an idle bus can be taken
    assign grant = dma0_request & no_command_state & ~refresh_active;

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            // Starts high so a timer already high is not an edge
            timer_sample <= 1'b1;
        end
        else
        begin
            timer_sample <= refresh_timer;
        end
    end

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            dma0_request <= 1'b0;
        end
        else if (timer_rise)
        begin
            dma0_request <= 1'b1;
        end
        else if (grant)
        begin
            dma0_request <= 1'b0;
        end
    end

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            refresh_active <= 1'b0;
            refresh_count  <= '0;
        end
        else if (grant)
        begin
            refresh_active <= 1'b1;
            refresh_count  <= REFRESH_CNT_W'(REFRESH_CYCLES - 1);
        end
        else if (refresh_active)
        begin
            if (refresh_count == '0)
            begin
                refresh_active <= 1'b0;
            end
            else
            begin
                refresh_count <= refresh_count - 1'b1;
            end
        end
    end

    // Acknowledge and bus hold move together
    assign dma0_acknowledge_n = ~refresh_active;
    assign address_enable_n   = ~refresh_active;

endmodule

`default_nettype wire

// File: window_ram.sv
`timescale 1ns/10ps
`default_nettype none

module window_ram
    import chipset_pkg::*;
(
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic [ADDR_W-1:0] address,
    input  wire logic [DATA_W-1:0] data_bus,
    input  wire logic              memory_read_n,
    input  wire logic              memory_write_n,
    input  wire logic [WAIT_W-1:0] ram_read_wait_cycle,
    input  wire logic [WAIT_W-1:0] ram_write_wait_cycle,
    output logic                   ram_select_n,
    output logic      [DATA_W-1:0] ram_read_data,
    output logic                   memory_access_ready
);

    logic [DATA_W-1:0]     ram [RAM_WORDS];
    logic [RAM_ADDR_W-1:0] ram_index;
    logic                  memory_command;
    logic                  memory_command_d;
    logic                  write_active_d;
    logic [WAIT_W-1:0]     wait_count;

    // Window match on the upper address bits
    assign ram_select_n = ~(address[ADDR_W-1:RAM_ADDR_W] == RAM_BASE[ADDR_W-1:RAM_ADDR_W]);
    assign ram_index    = address[RAM_ADDR_W-1:0];

    assign memory_command = ~memory_read_n | ~memory_write_n;

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            memory_command_d <= 1'b0;
            write_active_d   <= 1'b0;
            wait_count       <= '0;
        end
        else
        begin
            memory_command_d <= memory_command;
            write_active_d   <= ~memory_write_n;

            if (memory_command & ~memory_command_d & ~ram_select_n)
            begin
                wait_count <= ~memory_write_n ? ram_write_wait_cycle : ram_read_wait_cycle;
            end
            else if (wait_count != '0)
            begin
                wait_count <= wait_count - 1'b1;
            end
        end
    end

    assign memory_access_ready = (wait_count == '0);

    always_ff @(posedge clock)
    begin
        // Store once the write strobe has been released
        if (write_active_d & memory_write_n & ~ram_select_n)
        begin
            ram[ram_index] <= data_bus;
        end
        ram_read_data <= ram[ram_index];
    end

endmodule

`default_nettype wire

// File: chipset.sv
`timescale 1ns/10ps
`default_nettype none

module chipset
    import chipset_pkg::*;
(
    input  wire logic                clock,
    input  wire logic                reset,
    input  wire logic [ADDR_W-1:0]   cpu_address,
    input  wire logic [DATA_W-1:0]   cpu_data_bus,
    input  wire logic [STATUS_W-1:0] processor_status,
    input  wire logic                io_channel_ready,
    input  wire logic [DATA_W-1:0]   data_bus_ext,
    input  wire logic                refresh_timer,
    input  wire logic [WAIT_W-1:0]   ram_read_wait_cycle,
    input  wire logic [WAIT_W-1:0]   ram_write_wait_cycle,
    output logic      [ADDR_W-1:0]   address,
    output logic                     address_latch_enable,
    output logic      [DATA_W-1:0]   data_bus,
    output logic                     data_bus_direction,
    output logic      [DATA_W-1:0]   cpu_read_data,
    output logic                     io_read_n,
    output logic                     io_write_n,
    output logic                     memory_read_n,
    output logic                     memory_write_n,
    output logic                     processor_ready,
    output logic                     dma0_acknowledge_n,
    output logic                     address_enable_n
);

    logic              no_command_state;
    logic              ram_select_n;
    logic [DATA_W-1:0] ram_read_data;
    logic              memory_access_ready;

    bus_controller u_bus_controller
    (
        .clock                (clock),
        .reset                (reset),
        .processor_status     (processor_status),
        .cpu_address          (cpu_address),
        .cpu_data_bus         (cpu_data_bus),
        .address_enable_n     (address_enable_n),
        .address              (address),
        .data_bus             (data_bus),
        .address_latch_enable (address_latch_enable),
        .io_read_n            (io_read_n),
        .io_write_n           (io_write_n),
        .memory_read_n        (memory_read_n),
        .memory_write_n       (memory_write_n),
        .no_command_state     (no_command_state)
    );

    ready_generator u_ready_generator
    (
        .clock               (clock),
        .reset               (reset),
        .io_read_n           (io_read_n),
        .io_write_n          (io_write_n),
        .memory_read_n       (memory_read_n),
        .memory_write_n      (memory_write_n),
        .io_channel_ready    (io_channel_ready),
        .memory_access_ready (memory_access_ready),
        .processor_ready     (processor_ready)
    );

    refresh_dma u_refresh_dma
    (
        .clock              (clock),
        .reset              (reset),
        .refresh_timer      (refresh_timer),
        .no_command_state   (no_command_state),
        .dma0_acknowledge_n (dma0_acknowledge_n),
        .address_enable_n   (address_enable_n)
    );

    window_ram u_window_ram
    (
        .clock                (clock),
        .reset                (reset),
        .address              (address),
        .data_bus             (data_bus),
        .memory_read_n        (memory_read_n),
        .memory_write_n       (memory_write_n),
        .ram_read_wait_cycle  (ram_read_wait_cycle),
        .ram_write_wait_cycle (ram_write_wait_cycle),
        .ram_select_n         (ram_select_n),
        .ram_read_data        (ram_read_data),
        .memory_access_ready  (memory_access_ready)
    );

    // Read data source, RAM window first
    always_comb
    begin
        if (~ram_select_n && ~memory_read_n)
        begin
            cpu_read_data      = ram_read_data;
            data_bus_direction = 1'b0;
        end
        else if (~io_read_n || ~memory_read_n)
        begin
            cpu_read_data      = data_bus_ext;
            data_bus_direction = 1'b1;
        end
        else
        begin
            cpu_read_data      = '0;
            data_bus_direction = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: tb_chipset.sv
`timescale 1ns/10ps
`default_nettype none

module tb_chipset
    import chipset_pkg::*;
();

    localparam int TIMEOUT     = 100;
    localparam int HOLD_CLOCKS = 20;

    logic                clock;
    logic                reset;
    logic [ADDR_W-1:0]   cpu_address;
    logic [DATA_W-1:0]   cpu_data_bus;
    logic [STATUS_W-1:0] processor_status;
    logic                io_channel_ready;
    logic [DATA_W-1:0]   data_bus_ext;
    logic                refresh_timer;
    logic [WAIT_W-1:0]   ram_read_wait_cycle;
    logic [WAIT_W-1:0]   ram_write_wait_cycle;
    logic [ADDR_W-1:0]   address;
    logic                address_latch_enable;
    logic [DATA_W-1:0]   data_bus;
    logic                data_bus_direction;
    logic [DATA_W-1:0]   cpu_read_data;
    logic                io_read_n;
    logic                io_write_n;
    logic                memory_read_n;
    logic                memory_write_n;
    logic                processor_ready;
    logic                dma0_acknowledge_n;
    logic                address_enable_n;
    logic [3:0]          commands;

    int                  errors;
    int                  checks;
    int                  seed;
    logic [DATA_W-1:0]   model_mem [logic [RAM_ADDR_W-1:0]];

    chipset u_dut (.*);

    assign commands = {io_read_n, io_write_n, memory_read_n, memory_write_n};

    initial
    begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timed out after %0d clocks waiting for %s", TIMEOUT, what);
    endtask

    task automatic end_test(input string name, input int errors_before);
        $display("test %s %s", name, (errors == errors_before) ? "ok" : "has mismatches");
    endtask

    // Expected command levels, io read / io write / mem read / mem write
    function automatic logic [3:0] expected_commands(input logic [STATUS_W-1:0] status);
        case (status)
            STATUS_IO_READ:    return 4'b0111;
            STATUS_IO_WRITE:   return 4'b1011;
            STATUS_CODE_FETCH: return 4'b1101;
            STATUS_MEM_READ:   return 4'b1101;
            STATUS_MEM_WRITE:  return 4'b1110;
            default:           return 4'b1111;
        endcase
    endfunction

    // Window hit on the upper address bits, else the external bus
    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr,
                                                        input logic [DATA_W-1:0] ext,
                                                        input logic is_memory);
        if (is_memory && addr[ADDR_W-1:RAM_ADDR_W] == RAM_BASE[ADDR_W-1:RAM_ADDR_W])
            return model_mem.exists(addr[RAM_ADDR_W-1:0]) ?
                model_mem[addr[RAM_ADDR_W-1:0]] : 8'hxx;
        return ext;
    endfunction

    task automatic release_bus();
        @(posedge clock);
        processor_status <= STATUS_PASSIVE;
        io_channel_ready <= 1'b1;
    endtask

    task automatic run_cycle(input logic [STATUS_W-1:0] status, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input int hold,
                             output logic [DATA_W-1:0] rdata, output logic dir,
                             output int latency);
        int n;
        n = 0;
        rdata = '0;
        dir = 1'b0;
        latency = 0;
        @(posedge clock);
        processor_status <= status;
        cpu_address      <= addr;
        cpu_data_bus     <= wdata;
        if (hold > 0)
            io_channel_ready <= 1'b0;
        @(negedge clock);
        while (!address_latch_enable && n < TIMEOUT)
        begin
            @(negedge clock);
            n++;
        end
        if (!address_latch_enable)
        begin
            report_timeout("address_latch_enable");
            release_bus();
            return;
        end
        check_value("address", address, addr);
        @(negedge clock);
        check_value("address_latch_enable", address_latch_enable, 1'b0);
        check_value("commands", commands, expected_commands(status));
        if (status == STATUS_IO_WRITE || status == STATUS_MEM_WRITE)
            check_value("data_bus", data_bus, wdata);
        // I/O channel back-pressure
        for (int i = 0; i < hold; i++)
        begin
            check_value("processor_ready", processor_ready, 1'b0);
            @(negedge clock);
        end
        if (hold > 0)
        begin
            @(posedge clock);
            io_channel_ready <= 1'b1;
            @(negedge clock);
            check_value("processor_ready", processor_ready, 1'b0);
        end
        while (!processor_ready && latency < TIMEOUT)
        begin
            @(negedge clock);
            latency++;
        end
        if (!processor_ready)
        begin
            report_timeout("processor_ready");
            release_bus();
            return;
        end
        rdata = cpu_read_data;
        dir = data_bus_direction;
        @(posedge clock);
        processor_status <= STATUS_PASSIVE;
        @(negedge clock);
        n = 0;
        while (commands != 4'hf && n < TIMEOUT)
        begin
            @(negedge clock);
            n++;
        end
        if (commands != 4'hf)
            report_timeout("command release");
        // RAM write lands one clock after memory_write_n rises
        @(negedge clock);
    endtask

    task automatic start_refresh(output bit ok);
        int n;
        n = 0;
        @(posedge clock);
        refresh_timer <= 1'b1;
        @(negedge clock);
        while (dma0_acknowledge_n && n < TIMEOUT)
        begin
            @(negedge clock);
            n++;
        end
        ok = !dma0_acknowledge_n;
        if (!ok)
            report_timeout("dma0_acknowledge_n");
    endtask

    task automatic hold_no_command(input logic [STATUS_W-1:0] status);
        @(posedge clock);
        processor_status <= status;
        for (int i = 0; i < HOLD_CLOCKS; i++)
        begin
            @(negedge clock);
            check_value("commands", commands, 4'hf);
            check_value("processor_ready", processor_ready, 1'b0);
        end
        @(posedge clock);
        processor_status <= STATUS_PASSIVE;
        repeat (2) @(posedge clock);
        @(negedge clock);
    endtask

    // Refresh hold keeps commands off the bus
    always @(negedge clock)
    begin
        if (!reset && (!address_enable_n || !dma0_acknowledge_n))
        begin
            check_value("commands during refresh", commands, 4'hf);
            check_value("address_enable_n", address_enable_n, dma0_acknowledge_n);
        end
    end

    initial
    begin
        logic [31:0]       r;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] last_addr;
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] ext;
        logic [DATA_W-1:0] rdata;
        logic              dir;
        int                latency;
        int                rd_wait;
        int                low_clocks;
        int                mark;
        bit                ok;

        seed = 32'hd88a;
        errors = 0;
        checks = 0;
        reset = 1'b1;
        processor_status = STATUS_PASSIVE;
        cpu_address = '0;
        cpu_data_bus = '0;
        io_channel_ready = 1'b1;
        data_bus_ext = '0;
        refresh_timer = 1'b0;
        ram_read_wait_cycle = '0;
        ram_write_wait_cycle = '0;
        last_addr = '0;
        ext = '0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);

        mark = errors;
        check_value("commands", commands, 4'hf);
        check_value("dma0_acknowledge_n", dma0_acknowledge_n, 1'b1);
        check_value("address_enable_n", address_enable_n, 1'b1);
        check_value("processor_ready", processor_ready, 1'b0);
        check_value("address_latch_enable", address_latch_enable, 1'b0);
        end_test("reset", mark);

        mark = errors;
        for (int i = 0; i < 8; i++)
        begin
            r = $random(seed);
            addr = {RAM_BASE[ADDR_W-1:RAM_ADDR_W], r[RAM_ADDR_W-1:0]};
            wdata = r[17:10];
            rd_wait = int'(r[21:20]);
            @(posedge clock);
            ram_write_wait_cycle <= r[19:18];
            ram_read_wait_cycle  <= r[21:20];
            run_cycle(STATUS_MEM_WRITE, addr, wdata, 0, rdata, dir, latency);
            model_mem[addr[RAM_ADDR_W-1:0]] = wdata;
            run_cycle(STATUS_MEM_READ, addr, 8'h00, 0, rdata, dir, latency);
            check_value("cpu_read_data", rdata, expected_read(addr, ext, 1'b1));
            check_value("data_bus_direction", dir, 1'b0);
            if (latency < rd_wait + 1)
            begin
                errors++;
                $display("processor_ready rose %0d clocks after memory_read_n fell, wait was %0d",
                         latency, rd_wait);
            end
            last_addr = addr;
        end
        end_test("memory write and read in window", mark);

        mark = errors;
        for (int i = 0; i < 4; i++)
        begin
            r = $random(seed);
            addr = {r[19:10] | 10'h200, r[9:0]};
            ext = r[31:24];
            @(posedge clock);
            data_bus_ext <= ext;
            run_cycle(STATUS_MEM_READ, addr, 8'h00, 0, rdata, dir, latency);
            check_value("cpu_read_data", rdata, expected_read(addr, ext, 1'b1));
            check_value("data_bus_direction", dir, 1'b1);
        end
        end_test("memory read outside window", mark);

        mark = errors;
        r = $random(seed);
        run_cycle(STATUS_IO_WRITE, {4'h0, r[15:0]}, r[23:16], 0, rdata, dir, latency);
        r = $random(seed);
        addr = {4'h0, r[15:0]};
        ext = r[31:24];
        @(posedge clock);
        data_bus_ext <= ext;
        run_cycle(STATUS_IO_READ, addr, 8'h00, 0, rdata, dir, latency);
        check_value("cpu_read_data", rdata, expected_read(addr, ext, 1'b0));
        check_value("data_bus_direction", dir, 1'b1);
        r = $random(seed);
        // Hold past the I/O wait state so an ungated ready would show
        run_cycle(STATUS_IO_READ, addr, 8'h00, int'(r[3:0]) + 4, rdata, dir, latency);
        check_value("cpu_read_data", rdata, expected_read(addr, ext, 1'b0));
        end_test("io cycles", mark);

        mark = errors;
        start_refresh(ok);
        if (ok)
        begin
            low_clocks = 0;
            while (!dma0_acknowledge_n && low_clocks < TIMEOUT)
            begin
                @(negedge clock);
                low_clocks++;
            end
            check_value("dma0_acknowledge_n low clocks", low_clocks, REFRESH_CYCLES);
        end
        @(posedge clock);
        refresh_timer <= 1'b0;
        // CPU cycle issued while the refresh holds the bus
        start_refresh(ok);
        run_cycle(STATUS_MEM_READ, last_addr, 8'h00, 0, rdata, dir, latency);
        check_value("cpu_read_data", rdata, expected_read(last_addr, ext, 1'b1));
        check_value("data_bus_direction", dir, 1'b0);
        @(posedge clock);
        refresh_timer <= 1'b0;
        end_test("refresh", mark);

        mark = errors;
        hold_no_command(STATUS_INTA);
        hold_no_command(STATUS_HALT);
        end_test("interrupt acknowledge and halt", mark);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
chipset_pkg.sv
bus_controller.sv
ready_generator.sv
refresh_dma.sv
window_ram.sv
chipset.sv
tb_chipset.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_chipset
FILELIST = tb.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
